// ==== bench/clock_gen.sv ====
`default_nettype none

module clock_gen (
	output logic clock_o,
	output logic reset_o
);
	// Period of four, two high and two low
	initial begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o;
	end

	// Ten rising edges of reset, released just after the edge
	initial begin
		reset_o = 1'b1;
		repeat (10) @(posedge clock_o);
		#1 reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals for the closing line
int checks_run = 0;
int value_errors = 0;
int other_errors = 0;

// Whole response, write flag plus all eight words
task automatic check_resp(input string what, input mem_resp_t got, input mem_resp_t exp);
	int first_bad;
	checks_run++;
	if (got !== exp) begin
		value_errors++;
		first_bad = -1;
		// Lowest beat that differs
		for (int i = BURST_LEN - 1; i >= 0; i--) begin
			if (got.data[i] !== exp.data[i])
				first_bad = i;
		end
		$display("ERROR @%0t: %s, write %b expected %b, first bad beat %0d",
			$time, what, got.write, exp.write, first_bad);
		$display("ERROR @%0t: %s, got data %h expected %h",
			$time, what, got.data, exp.data);
	end
endtask

// Single status bit such as req_ready or resp_valid
task automatic check_ready(input string what, input logic got, input logic exp);
	checks_run++;
	if (got !== exp) begin
		value_errors++;
		$display("ERROR @%0t: %s, got %b expected %b", $time, what, got, exp);
	end
endtask

// Anything that is not a wrong value, e.g. a bad ordering
task automatic report_failure(input string what);
	other_errors++;
	$display("Failure at time %0t: %s", $time, what);
endtask

`endif

// ==== bench/tb_mem_subsystem.sv ====
`default_nettype none

module tb_mem_subsystem;
	import mem_pkg::*;

	// Six directed tests, 2000 time units of watchdog budget each
	localparam int NUM_TESTS = 6;
	localparam int RANDOM_OPS = 40;
	// Burst slots shared by the random traffic
	localparam int POOL_SLOTS = 16;

	logic clock;
	logic reset;
	logic [NUM_PORTS-1:0] req_valid;
	logic [NUM_PORTS-1:0] req_ready;
	mem_req_t [NUM_PORTS-1:0] req;
	logic [NUM_PORTS-1:0] resp_valid;
	logic [NUM_PORTS-1:0] resp_ready;
	mem_resp_t [NUM_PORTS-1:0] resp;

	int cycle = 0;
	// Cycle in which each port's response was seen
	int done_at [NUM_PORTS];
	logic [31:0] lfsr_state = 32'hb080a73c;
	// Reference copy of the backing store
	logic [DATA_W-1:0] model_mem [MEM_WORDS];

	`include "tb_checks.svh"

	clock_gen clock_gen_i (
		.clock_o(clock),
		.reset_o(reset)
	);

	mem_subsystem mem_subsystem_i (
		.clock_i(clock),
		.reset_i(reset),
		.req_valid_i(req_valid),
		.req_ready_o(req_ready),
		.req_i(req),
		.resp_valid_o(resp_valid),
		.resp_ready_i(resp_ready),
		.resp_o(resp)
	);

	always @(posedge clock)
		cycle <= cycle + 1;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic burst_t random_burst();
		burst_t d;
		for (int i = 0; i < BURST_LEN; i++)
			d[i] = DATA_W'(random_bits(DATA_W));
		return d;
	endfunction

	// Low three bits dropped, bits above the array wrap
	function automatic logic [MEM_AW-1:0] word_index(input logic [ADDR_W-1:0] addr,
			input int beat);
		return {addr[MEM_AW-1:BEAT_W], BEAT_W'(beat)};
	endfunction

	function automatic burst_t model_read(input logic [ADDR_W-1:0] addr);
		burst_t d;
		for (int i = 0; i < BURST_LEN; i++)
			d[i] = model_mem[word_index(addr, i)];
		return d;
	endfunction

	function automatic void model_write(input logic [ADDR_W-1:0] addr,
			input logic [DM_W-1:0] dm, input burst_t data);
		for (int i = 0; i < BURST_LEN; i++) begin
			for (int b = 0; b < DM_W; b++) begin
				// Set mask bit keeps the stored byte
				if (!dm[b])
					model_mem[word_index(addr, i)][b*8 +: 8] = data[i][b*8 +: 8];
			end
		end
	endfunction

	function automatic mem_req_t make_req(input logic [ADDR_W-1:0] addr, input logic write,
			input logic [DM_W-1:0] dm, input burst_t data);
		mem_req_t r;
		r.addr = addr;
		r.write = write;
		r.dm = dm;
		r.data = data;
		return r;
	endfunction

	// One private burst per port for the directed tests
	function automatic logic [ADDR_W-1:0] port_addr(input int p);
		return ADDR_W'(256 + 64 * p);
	endfunction

	// Upper bits alias onto the same words through the wrap
	function automatic logic [ADDR_W-1:0] pool_addr(input int slot,
			input logic [ADDR_W-MEM_AW-1:0] upper);
		return {upper, 5'b10000, slot[3:0], {BEAT_W{1'b0}}};
	endfunction

	// Hold valid until an edge with ready high
	task automatic issue_req(input int p, input mem_req_t r);
		logic accepted;
		req[p] = r;
		req_valid[p] = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			accepted = req_ready[p];
			@(posedge clock);
			#1;
		end
		req_valid[p] = 1'b0;
	endtask

	task automatic take_resp(input int p, output mem_resp_t r, output int at);
		resp_ready[p] = 1'b1;
		while (resp_valid[p] !== 1'b1) begin
			@(posedge clock);
			#1;
		end
		r = resp[p];
		at = cycle;
		@(posedge clock);
		#1;
		resp_ready[p] = 1'b0;
	endtask

	// Expected value fixed at issue, in arbitration order
	task automatic run_op(input int p, input mem_req_t r, output int at);
		mem_resp_t exp;
		mem_resp_t got;
		exp.write = r.write;
		if (r.write) begin
			exp.data = burst_t'(0);
			model_write(r.addr, r.dm, r.data);
		end else begin
			exp.data = model_read(r.addr);
		end
		issue_req(p, r);
		take_resp(p, got, at);
		check_resp($sformatf("port %0d %s at %h", p, r.write ? "write" : "read", r.addr),
			got, exp);
	endtask

	task automatic reset_state_test();
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_ready($sformatf("port %0d req_ready after reset", p), req_ready[p], 1'b1);
			check_ready($sformatf("port %0d resp_valid after reset", p), resp_valid[p], 1'b0);
		end
	endtask

	task automatic port_loopback_test();
		for (int p = 0; p < NUM_PORTS; p++) begin
			run_op(p, make_req(port_addr(p), 1'b1, '0, random_burst()), done_at[p]);
			run_op(p, make_req(port_addr(p), 1'b0, '0, burst_t'(0)), done_at[p]);
		end
	endtask

	task automatic byte_mask_test();
		logic [ADDR_W-1:0] addr;
		addr = ADDR_W'(32'h300);
		run_op(2, make_req(addr, 1'b1, 2'b00, random_burst()), done_at[2]);
		// Low byte masked off, high byte new
		run_op(2, make_req(addr, 1'b1, 2'b01, random_burst()), done_at[2]);
		run_op(2, make_req(addr, 1'b0, 2'b00, burst_t'(0)), done_at[2]);
	endtask

	// All four in the same cycle, answers in priority order
	task automatic contention_round(input logic is_write);
		mem_req_t r [NUM_PORTS];
		for (int p = 0; p < NUM_PORTS; p++)
			r[p] = make_req(port_addr(p), is_write, '0, random_burst());
		fork
			run_op(0, r[0], done_at[0]);
			run_op(1, r[1], done_at[1]);
			run_op(2, r[2], done_at[2]);
			run_op(3, r[3], done_at[3]);
		join
		for (int p = 1; p < NUM_PORTS; p++) begin
			if (done_at[p] <= done_at[p-1])
				report_failure($sformatf("port %0d answered no later than port %0d",
					p, p - 1));
		end
	endtask

	task automatic contention_test();
		contention_round(1'b1);
		contention_round(1'b0);
	endtask

	// Port 1 stalls its response while 0, 2 and 3 keep going
	task automatic back_pressure_test();
		mem_req_t others [NUM_PORTS];
		mem_resp_t exp1;
		mem_resp_t held;
		mem_resp_t got;
		int at;
		exp1.write = 1'b0;
		exp1.data = model_read(port_addr(1));
		others[0] = make_req(port_addr(0), 1'b1, 2'b10, random_burst());
		others[2] = make_req(port_addr(2), 1'b0, '0, burst_t'(0));
		others[3] = make_req(port_addr(3), 1'b1, '0, random_burst());
		fork
			begin
				issue_req(1, make_req(port_addr(1), 1'b0, '0, burst_t'(0)));
				while (resp_valid[1] !== 1'b1) begin
					@(posedge clock);
					#1;
				end
				held = resp[1];
				check_resp("port 1 stalled response", held, exp1);
				repeat (50) begin
					check_ready("port 1 req_ready while stalled", req_ready[1], 1'b0);
					check_ready("port 1 resp_valid while stalled", resp_valid[1], 1'b1);
					check_resp("port 1 held response", resp[1], held);
					@(posedge clock);
					#1;
				end
				take_resp(1, got, at);
				check_resp("port 1 response after stall", got, exp1);
			end
			fork
				run_op(0, others[0], done_at[0]);
				run_op(2, others[2], done_at[2]);
				run_op(3, others[3], done_at[3]);
			join
		join
		// Other ports finish while port 1 still holds its answer
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (p != 1 && done_at[p] >= at)
				report_failure($sformatf("port %0d finished only after port 1 was released",
					p));
		end
	endtask

	task automatic random_ops_test();
		logic [31:0] bits;
		logic [ADDR_W-1:0] addr;
		int p;
		// Every slot gets known data first
		for (int s = 0; s < POOL_SLOTS; s++)
			run_op(s % NUM_PORTS, make_req(pool_addr(s, '0), 1'b1, '0, random_burst()),
				done_at[0]);
		for (int n = 0; n < RANDOM_OPS; n++) begin
			p = int'(random_bits(PORT_W));
			bits = random_bits(ADDR_W - MEM_AW);
			addr = pool_addr(int'(random_bits(4)), bits[ADDR_W-MEM_AW-1:0]);
			bits = random_bits(1 + DM_W);
			run_op(p, make_req(addr, bits[DM_W], bits[DM_W-1:0], random_burst()), done_at[p]);
		end
	endtask

	initial begin
		req_valid = '0;
		req = '0;
		resp_ready = '0;
		@(negedge reset);
		@(posedge clock);
		#1;
		reset_state_test();
		port_loopback_test();
		byte_mask_test();
		contention_test();
		back_pressure_test();
		random_ops_test();
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks_run, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog sized from the number of tests
	initial begin
		#(NUM_TESTS * 2000);
		$display("Watchdog expired at %0t, the tests did not finish", $time);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/burst_port.sv
verilog/mem_arbiter.sv
verilog/burst_memory.sv
verilog/mem_subsystem.sv
bench/clock_gen.sv
bench/tb_mem_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_mem_subsystem \
	-Mdir obj_dir -o tb_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; grep -qx "Everything OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verilog/burst_memory.sv ====
`default_nettype none

module burst_memory (
	input logic clock_i,
	input logic reset_i,
	// Command from the arbiter
	input logic enable_i,
	input mem_pkg::mem_cmd_t cmd_i,
	input logic [mem_pkg::DATA_W-1:0] wr_word_i,
	// Handshake and read data
	output logic busy_o,
	output logic valid_o,
	output logic [mem_pkg::DATA_W-1:0] rd_word_o
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		M_IDLE,
		M_BUSY,
		M_CAS,
		M_DATA
	} state_t;

	state_t state;
	// Command held for the whole burst
	mem_cmd_t cmd_q;
	logic [CAS_W-1:0] cas_cnt;
	logic [BEAT_W-1:0] beat_cnt;
	// Aligned burst base inside the array
	logic [MEM_AW-BEAT_W-1:0] base;
	logic [MEM_AW-1:0] wr_addr;
	// Read runs one beat ahead of valid
	logic [BEAT_W-1:0] fetch_beat;

	logic [DATA_W-1:0] mem [MEM_WORDS];

	// Low three bits dropped, high bits wrap
	assign base = cmd_q.addr[MEM_AW-1:BEAT_W];
	assign wr_addr = {base, beat_cnt};
	assign fetch_beat = (state == M_DATA) ? beat_cnt + 1'b1 : '0;

	// Single-cycle busy pulse after accept
	assign busy_o = (state == M_BUSY);
	assign valid_o = (state == M_DATA);

	// Burst sequencer
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state <= M_IDLE;
			cas_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				M_IDLE: begin
					if (enable_i)
						state <= M_BUSY;
				end
				M_BUSY: begin
					state <= M_CAS;
					cas_cnt <= CAS_W'(CAS_CYCLES - 1);
				end
				M_CAS: begin
					// CAS delay runs out, data next
					if (cas_cnt == '0) begin
						state <= M_DATA;
						beat_cnt <= '0;
					end else begin
						cas_cnt <= cas_cnt - 1'b1;
					end
				end
				M_DATA: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == BEAT_W'(BURST_LEN - 1))
						state <= M_IDLE;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// Command capture on accept
	always_ff @(posedge clock_i) begin
		if (state == M_IDLE && enable_i)
			cmd_q <= cmd_i;
	end

	// Storage, registered read and masked write
	always_ff @(posedge clock_i) begin
		if (cmd_q.rd)
			rd_word_o <= mem[{base, fetch_beat}];
		if (state == M_DATA && cmd_q.wr) begin
			// Set dm bit keeps the old byte
			for (int b = 0; b < DM_W; b++) begin
				if (!cmd_q.dm[b])
					mem[wr_addr][b*8 +: 8] <= wr_word_i[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/burst_port.sv ====
`default_nettype none

module burst_port (
	input logic clock_i,
	input logic reset_i,
	// Client request channel
	input logic req_valid_i,
	output logic req_ready_o,
	input mem_pkg::mem_req_t req_i,
	// Client response channel
	output logic resp_valid_o,
	input logic resp_ready_i,
	output mem_pkg::mem_resp_t resp_o,
	// Toward the arbiter
	output logic arb_req_o,
	output mem_pkg::mem_cmd_t cmd_o,
	input logic grant_i,
	input logic beat_valid_i,
	input logic [mem_pkg::DATA_W-1:0] rd_word_i,
	output logic [mem_pkg::DATA_W-1:0] wr_word_o
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_XFER,
		P_RESP
	} state_t;

	state_t state;
	// Held copy of the accepted request
	mem_req_t req_q;
	// Read beats land here by beat index
	burst_t rd_burst;
	logic [BEAT_W-1:0] beat_cnt;
	logic arb_req_q;

	// Only one request in flight per port
	assign req_ready_o = (state == P_IDLE);
	assign resp_valid_o = (state == P_RESP);
	assign arb_req_o = arb_req_q;

	// Write flag becomes a clean rd/wr pair
	assign cmd_o.addr = req_q.addr;
	assign cmd_o.rd = !req_q.write;
	assign cmd_o.wr = req_q.write;
	assign cmd_o.dm = req_q.dm;

	// Write beat follows our own counter
	assign wr_word_o = req_q.data[beat_cnt];

	// Writes answer with no data
	assign resp_o.write = req_q.write;
	assign resp_o.data = req_q.write ? '0 : rd_burst;

	// Control FSM
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state <= P_IDLE;
			arb_req_q <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				P_IDLE: begin
					if (req_valid_i) begin
						state <= P_XFER;
						arb_req_q <= 1'b1;
						beat_cnt <= '0;
					end
				end
				P_XFER: begin
					// Grant seen, request no longer needed
					if (grant_i)
						arb_req_q <= 1'b0;
					if (beat_valid_i) begin
						beat_cnt <= beat_cnt + 1'b1;
						// Eighth beat, response goes up next cycle
						if (beat_cnt == BEAT_W'(BURST_LEN - 1))
							state <= P_RESP;
					end
				end
				P_RESP: begin
					// Held here until the client takes it
					if (resp_ready_i)
						state <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	// Payload, no reset
	always_ff @(posedge clock_i) begin
		if (req_valid_i && req_ready_o)
			req_q <= req_i;
		if (beat_valid_i && !req_q.write)
			rd_burst[beat_cnt] <= rd_word_i;
	end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
	input logic clock_i,
	input logic reset_i,
	// Port side
	input logic [mem_pkg::NUM_PORTS-1:0] port_req_i,
	input mem_pkg::mem_cmd_t [mem_pkg::NUM_PORTS-1:0] port_cmd_i,
	input logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_W-1:0] port_wr_word_i,
	output logic [mem_pkg::NUM_PORTS-1:0] grant_o,
	output logic [mem_pkg::NUM_PORTS-1:0] beat_valid_o,
	output logic [mem_pkg::DATA_W-1:0] rd_word_o,
	// Memory side
	output logic enable_o,
	output mem_pkg::mem_cmd_t cmd_o,
	output logic [mem_pkg::DATA_W-1:0] wr_word_o,
	input logic busy_i,
	input logic valid_i,
	input logic [mem_pkg::DATA_W-1:0] rd_word_i
);
	import mem_pkg::*;

	// IDLE picks a port, ACTIVE waits for busy, INCYCLE moves the data
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		INCYCLE
	} state_t;

	state_t state;
	// Priority pick from the current requests
	logic pick_any;
	logic [PORT_W-1:0] pick_idx;
	// Port that owns the memory
	logic [PORT_W-1:0] grant_idx;
	logic [BEAT_W-1:0] beat_cnt;
	// Command latched at grant time
	mem_cmd_t cmd_q;

	// Fixed priority, port 0 wins
	always_comb begin
		pick_any = 1'b1;
		pick_idx = '0;
		casez (port_req_i)
			4'b???1: pick_idx = PORT_W'(0);
			4'b??10: pick_idx = PORT_W'(1);
			4'b?100: pick_idx = PORT_W'(2);
			4'b1000: pick_idx = PORT_W'(3);
			default: pick_any = 1'b0;
		endcase
	end

	assign cmd_o = cmd_q;

	// Data only flows while the burst runs
	always_comb begin
		if (state == INCYCLE) begin
			wr_word_o = port_wr_word_i[grant_idx];
			rd_word_o = rd_word_i;
		end else begin
			wr_word_o = '0;
			rd_word_o = '0;
		end
	end

	// Beat strobe to the granted port alone
	assign beat_valid_o = (state == INCYCLE && valid_i) ? grant_o : '0;

	// Sequencer
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state <= IDLE;
			grant_o <= '0;
			enable_o <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Grant and enable rise on the same edge
					if (pick_any) begin
						state <= ACTIVE;
						grant_o <= NUM_PORTS'(1) << pick_idx;
						enable_o <= 1'b1;
						beat_cnt <= '0;
					end
				end
				ACTIVE: begin
					// Controller took the command
					if (busy_i) begin
						enable_o <= 1'b0;
						state <= INCYCLE;
					end
				end
				INCYCLE: begin
					if (valid_i) begin
						if (beat_cnt == BEAT_W'(BURST_LEN - 1)) begin
							// Last beat, release the port
							grant_o <= '0;
							beat_cnt <= '0;
							state <= IDLE;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Winner's command and index, no reset needed
	always_ff @(posedge clock_i) begin
		if (state == IDLE && pick_any) begin
			cmd_q <= port_cmd_i[pick_idx];
			grant_idx <= pick_idx;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// Memory geometry
	localparam int ADDR_W = 23;
	localparam int DATA_W = 16;
	// One mask bit per byte
	localparam int DM_W = 2;

	// Burst shape, always eight beats on an aligned address
	localparam int BURST_LEN = 8;
	localparam int BEAT_W = $clog2(BURST_LEN);

	// Client side
	localparam int NUM_PORTS = 4;
	localparam int PORT_W = $clog2(NUM_PORTS);

	// Backing store, upper address bits wrap
	localparam int MEM_WORDS = 4096;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// Gap between busy and the first data beat
	localparam int CAS_CYCLES = 2;
	localparam int CAS_W = $clog2(CAS_CYCLES + 1);

	// One full burst of words, beat 0 in the low slot
	typedef logic [BURST_LEN-1:0][DATA_W-1:0] burst_t;

	// Client request, data only meaningful for writes
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic write;
		logic [DM_W-1:0] dm;
		burst_t data;
	} mem_req_t;

	// Client response, data zero for writes
	typedef struct packed {
		logic write;
		burst_t data;
	} mem_resp_t;

	// Command toward the controller, exactly one of rd and wr
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic rd;
		logic wr;
		logic [DM_W-1:0] dm;
	} mem_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
	input logic clock_i,
	input logic reset_i,
	// Per-port request channels
	input logic [mem_pkg::NUM_PORTS-1:0] req_valid_i,
	output logic [mem_pkg::NUM_PORTS-1:0] req_ready_o,
	input mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0] req_i,
	// Per-port response channels
	output logic [mem_pkg::NUM_PORTS-1:0] resp_valid_o,
	input logic [mem_pkg::NUM_PORTS-1:0] resp_ready_i,
	output mem_pkg::mem_resp_t [mem_pkg::NUM_PORTS-1:0] resp_o
);
	import mem_pkg::*;

	// Ports to arbiter
	logic [NUM_PORTS-1:0] arb_req;
	mem_cmd_t [NUM_PORTS-1:0] port_cmd;
	logic [NUM_PORTS-1:0][DATA_W-1:0] port_wr_word;
	logic [NUM_PORTS-1:0] grant;
	logic [NUM_PORTS-1:0] beat_valid;
	// Read word shared by all ports, qualified by beat_valid
	logic [DATA_W-1:0] arb_rd_word;

	// Arbiter to memory
	logic mem_enable;
	mem_cmd_t mem_cmd;
	logic [DATA_W-1:0] mem_wr_word;
	logic mem_busy;
	logic mem_valid;
	logic [DATA_W-1:0] mem_rd_word;

	// Four identical client ports
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		burst_port port_i (
			.clock_i(clock_i),
			.reset_i(reset_i),
			.req_valid_i(req_valid_i[p]),
			.req_ready_o(req_ready_o[p]),
			.req_i(req_i[p]),
			.resp_valid_o(resp_valid_o[p]),
			.resp_ready_i(resp_ready_i[p]),
			.resp_o(resp_o[p]),
			.arb_req_o(arb_req[p]),
			.cmd_o(port_cmd[p]),
			.grant_i(grant[p]),
			.beat_valid_i(beat_valid[p]),
			.rd_word_i(arb_rd_word),
			.wr_word_o(port_wr_word[p])
		);
	end

	mem_arbiter arbiter_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.port_req_i(arb_req),
		.port_cmd_i(port_cmd),
		.port_wr_word_i(port_wr_word),
		.grant_o(grant),
		.beat_valid_o(beat_valid),
		.rd_word_o(arb_rd_word),
		.enable_o(mem_enable),
		.cmd_o(mem_cmd),
		.wr_word_o(mem_wr_word),
		.busy_i(mem_busy),
		.valid_i(mem_valid),
		.rd_word_i(mem_rd_word)
	);

	burst_memory memory_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(mem_enable),
		.cmd_i(mem_cmd),
		.wr_word_i(mem_wr_word),
		.busy_o(mem_busy),
		.valid_o(mem_valid),
		.rd_word_o(mem_rd_word)
	);

endmodule

`default_nettype wire
